//--- axil_sram.f
hdl/axil_pkg.sv
hdl/axil_if.sv
hdl/axil_master_wrap.sv
hdl/axil_sram_slave.sv
hdl/axil_sram_top.sv
test/tb_clkgen.sv
test/axil_sram_properties.sv
test/tb_axil_sram.sv

//--- hdl/axil_if.sv
// AXI-lite interface with master and slave modports
interface axil_if #(
  parameter int DATA_WIDTH = 64,
  parameter int ADDR_WIDTH = 32
);

  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  // Write address channel
  logic                   awvalid;
  logic                   awready;
  logic [ADDR_WIDTH-1:0]  awaddr;
  axil_pkg::axil_prot_t   awprot;

  // Write data channel
  logic                   wvalid;
  logic                   wready;
  logic [DATA_WIDTH-1:0]  wdata;
  logic [STRB_WIDTH-1:0]  wstrb;  // One bit per byte lane

  // Write response channel
  logic                   bvalid;
  logic                   bready;
  axil_pkg::axil_resp_t   bresp;

  // Read address channel
  logic                   arvalid;
  logic                   arready;
  logic [ADDR_WIDTH-1:0]  araddr;
  axil_pkg::axil_prot_t   arprot;

  // Read data channel
  logic                   rvalid;
  logic                   rready;
  logic [DATA_WIDTH-1:0]  rdata;
  axil_pkg::axil_resp_t   rresp;

  // ------------------------------------------------------------------------
  // Modports
  // ------------------------------------------------------------------------
  modport master (
    output awvalid, awaddr, awprot,
    output wvalid, wdata, wstrb,
    output bready,
    output arvalid, araddr, arprot,
    output rready,
    input  awready, wready, bvalid, bresp,
    input  arready, rvalid, rdata, rresp
  );

  modport slave (
    input  awvalid, awaddr, awprot,
    input  wvalid, wdata, wstrb,
    input  bready,
    input  arvalid, araddr, arprot,
    input  rready,
    output awready, wready, bvalid, bresp,
    output arready, rvalid, rdata, rresp
  );

endinterface

//--- hdl/axil_master_wrap.sv
// AXI-lite master wrapper: core request port to AXI-lite read and write FSMs
module axil_master_wrap #(
  parameter int  DATA_WIDTH = 64,
  parameter int  ADDR_WIDTH = 32,
  localparam int STRB_WIDTH = DATA_WIDTH / 8
) (
  input  logic                  i_aclk,
  input  logic                  i_arst_n,

  // Core side request port
  input  logic                  i_rw_valid,
  input  logic                  i_rw_ren,
  input  logic                  i_rw_wen,
  input  logic [ADDR_WIDTH-1:0] i_rw_addr,
  input  logic [DATA_WIDTH-1:0] i_rw_wdata,
  input  logic [STRB_WIDTH-1:0] i_rw_strb,
  output logic                  o_rw_ready,  // One-cycle completion pulse
  output logic [DATA_WIDTH-1:0] o_rw_rdata,
  output axil_pkg::axil_resp_t  o_rw_resp,

  axil_if.master                m_axil
);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ADDR,
    WR_DATA,
    WR_RESP
  } write_state_t;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA
  } read_state_t;

  write_state_t wr_state;
  read_state_t  rd_state;

  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic ar_fire;
  logic r_fire;
  logic wr_start;
  logic rd_start;

  // ------------------------------------------------------------------------
  // Handshakes
  // ------------------------------------------------------------------------
  assign aw_fire = m_axil.awvalid & m_axil.awready;
  assign w_fire  = m_axil.wvalid  & m_axil.wready;
  assign b_fire  = m_axil.bvalid  & m_axil.bready;
  assign ar_fire = m_axil.arvalid & m_axil.arready;
  assign r_fire  = m_axil.rvalid  & m_axil.rready;

  // Request is still held high during the ready pulse, so skip that cycle
  assign wr_start = i_rw_valid & i_rw_wen & ~o_rw_ready;
  assign rd_start = i_rw_valid & i_rw_ren & ~o_rw_ready;

  // ------------------------------------------------------------------------
  // Write FSM
  // ------------------------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_state <= WR_IDLE;
    end else begin
      case (wr_state)
        WR_IDLE: if (wr_start) wr_state <= WR_ADDR;
        WR_ADDR: if (aw_fire)  wr_state <= WR_DATA;
        WR_DATA: if (w_fire)   wr_state <= WR_RESP;
        WR_RESP: if (b_fire)   wr_state <= WR_IDLE;
        default:               wr_state <= WR_IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // Read FSM
  // ------------------------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rd_state <= RD_IDLE;
    end else begin
      case (rd_state)
        RD_IDLE: if (rd_start) rd_state <= RD_ADDR;
        RD_ADDR: if (ar_fire)  rd_state <= RD_DATA;
        RD_DATA: if (r_fire)   rd_state <= RD_IDLE;
        default:               rd_state <= RD_IDLE;
      endcase
    end
  end

  // Channel controls come straight from the state
  assign m_axil.awvalid = (wr_state == WR_ADDR);
  assign m_axil.awaddr  = i_rw_addr;
  assign m_axil.awprot  = axil_pkg::PROT_DATA_SECURE_UNPRIV;
  assign m_axil.wvalid  = (wr_state == WR_DATA);
  assign m_axil.wdata   = i_rw_wdata;
  assign m_axil.wstrb   = i_rw_strb;
  assign m_axil.bready  = (wr_state == WR_RESP);

  assign m_axil.arvalid = (rd_state == RD_ADDR);
  assign m_axil.araddr  = i_rw_addr;
  assign m_axil.arprot  = axil_pkg::PROT_DATA_SECURE_UNPRIV;
  assign m_axil.rready  = (rd_state == RD_DATA);

  // ------------------------------------------------------------------------
  // Completion
  // ------------------------------------------------------------------------

  // Read data kept until the next read completes
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_rw_rdata <= '0;
      o_rw_resp  <= axil_pkg::RESP_OKAY;
    end else if (r_fire) begin
      o_rw_rdata <= m_axil.rdata;
      o_rw_resp  <= m_axil.rresp;
    end else if (b_fire) begin
      o_rw_resp  <= m_axil.bresp;
    end
  end

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_rw_ready <= 1'b0;
    end else begin
      o_rw_ready <= b_fire | r_fire;  // High one cycle after last transfer
    end
  end

endmodule

//--- hdl/axil_pkg.sv
// AXI-lite response and protection types with their constant codes
package axil_pkg;

  // ------------------------------------------------------------------------
  // Response channel
  // ------------------------------------------------------------------------

  // Shared by the B and R channels
  typedef logic [1:0] axil_resp_t;

  localparam axil_resp_t RESP_OKAY   = 2'b00;  // Normal access done
  localparam axil_resp_t RESP_SLVERR = 2'b10;  // Slave saw a bad access

  // ------------------------------------------------------------------------
  // Protection field
  // ------------------------------------------------------------------------

  // Bit 0 privileged, bit 1 non-secure, bit 2 instruction fetch
  typedef logic [2:0] axil_prot_t;

  // Plain data access, secure, unprivileged.
  // All three bits cleared
  localparam axil_prot_t PROT_DATA_SECURE_UNPRIV = 3'b000;

endpackage

//--- hdl/axil_sram_slave.sv
// AXI-lite SRAM slave with byte-strobe writes and SLVERR on out-of-range words
module axil_sram_slave #(
  parameter int  DATA_WIDTH = 64,
  parameter int  ADDR_WIDTH = 32,
  parameter int  MEM_DEPTH  = 256,
  localparam int STRB_WIDTH = DATA_WIDTH / 8
) (
  input  logic   i_aclk,
  input  logic   i_arst_n,

  axil_if.slave  s_axil
);

  localparam int BYTE_OFF = $clog2(STRB_WIDTH);
  localparam int WORD_W   = ADDR_WIDTH - BYTE_OFF;
  localparam int IDX_W    = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

  typedef logic [WORD_W-1:0] word_idx_t;  // Byte address without lane bits

  // ST_WAIT is only passed by the write path
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_WAIT,
    ST_DATA,
    ST_RESP
  } slave_state_t;

  slave_state_t wr_state;
  slave_state_t rd_state;

  logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];

  word_idx_t wr_idx;  // Captured on AW
  logic      wr_err;
  word_idx_t ar_idx;

  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic ar_fire;
  logic r_fire;

  function automatic logic in_range(input word_idx_t idx);
    return idx < word_idx_t'(MEM_DEPTH);
  endfunction

  assign aw_fire = s_axil.awvalid & s_axil.awready;
  assign w_fire  = s_axil.wvalid  & s_axil.wready;
  assign b_fire  = s_axil.bvalid  & s_axil.bready;
  assign ar_fire = s_axil.arvalid & s_axil.arready;
  assign r_fire  = s_axil.rvalid  & s_axil.rready;

  assign ar_idx = s_axil.araddr[ADDR_WIDTH-1:BYTE_OFF];

  // ------------------------------------------------------------------------
  // Write path
  // ------------------------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_state <= ST_IDLE;
    end else begin
      case (wr_state)
        ST_IDLE: if (s_axil.awvalid) wr_state <= ST_ADDR;
        ST_ADDR: if (aw_fire)        wr_state <= ST_WAIT;
        ST_WAIT: if (s_axil.wvalid)  wr_state <= ST_DATA;
        ST_DATA: if (w_fire)         wr_state <= ST_RESP;
        ST_RESP: if (b_fire)         wr_state <= ST_IDLE;
        default:                     wr_state <= ST_IDLE;
      endcase
    end
  end

  assign s_axil.awready = (wr_state == ST_ADDR);
  assign s_axil.wready  = (wr_state == ST_DATA);
  assign s_axil.bvalid  = (wr_state == ST_RESP);

  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      wr_idx <= s_axil.awaddr[ADDR_WIDTH-1:BYTE_OFF];
      wr_err <= !in_range(s_axil.awaddr[ADDR_WIDTH-1:BYTE_OFF]);
    end
    if (w_fire) begin
      s_axil.bresp <= wr_err ? axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY;
    end
  end

  // Only strobed lanes change, bad address leaves memory alone
  always_ff @(posedge i_aclk) begin
    if (w_fire && !wr_err) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (s_axil.wstrb[b]) begin
          mem[wr_idx[IDX_W-1:0]][8*b +: 8] <= s_axil.wdata[8*b +: 8];
        end
      end
    end
  end

  // ------------------------------------------------------------------------
  // Read path
  // ------------------------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rd_state <= ST_IDLE;
    end else begin
      case (rd_state)
        ST_IDLE: if (s_axil.arvalid) rd_state <= ST_ADDR;
        ST_ADDR: if (ar_fire)        rd_state <= ST_RESP;
        ST_RESP: if (r_fire)         rd_state <= ST_IDLE;
        default:                     rd_state <= ST_IDLE;
      endcase
    end
  end

  assign s_axil.arready = (rd_state == ST_ADDR);
  assign s_axil.rvalid  = (rd_state == ST_RESP);

  // Data and response ready one cycle after AR
  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      if (in_range(ar_idx)) begin
        s_axil.rdata <= mem[ar_idx[IDX_W-1:0]];
        s_axil.rresp <= axil_pkg::RESP_OKAY;
      end else begin
        s_axil.rdata <= '0;  // Zero data on error
        s_axil.rresp <= axil_pkg::RESP_SLVERR;
      end
    end
  end

endmodule

//--- hdl/axil_sram_top.sv
// Top level: AXI-lite master wrapper and SRAM slave joined by one interface
module axil_sram_top #(
  parameter int  DATA_WIDTH = 64,
  parameter int  ADDR_WIDTH = 32,
  parameter int  MEM_DEPTH  = 256,
  localparam int STRB_WIDTH = DATA_WIDTH / 8
) (
  input  logic                  i_aclk,
  input  logic                  i_arst_n,

  input  logic                  i_rw_valid,
  input  logic                  i_rw_ren,
  input  logic                  i_rw_wen,
  input  logic [ADDR_WIDTH-1:0] i_rw_addr,
  input  logic [DATA_WIDTH-1:0] i_rw_wdata,
  input  logic [STRB_WIDTH-1:0] i_rw_strb,
  output logic                  o_rw_ready,
  output logic [DATA_WIDTH-1:0] o_rw_rdata,
  output logic [1:0]            o_rw_resp   // OKAY or SLVERR
);

  axil_if #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) axil ();

  axil_master_wrap #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_master (
    .i_aclk     (i_aclk),
    .i_arst_n   (i_arst_n),
    .i_rw_valid (i_rw_valid),
    .i_rw_ren   (i_rw_ren),
    .i_rw_wen   (i_rw_wen),
    .i_rw_addr  (i_rw_addr),
    .i_rw_wdata (i_rw_wdata),
    .i_rw_strb  (i_rw_strb),
    .o_rw_ready (o_rw_ready),
    .o_rw_rdata (o_rw_rdata),
    .o_rw_resp  (o_rw_resp),
    .m_axil     (axil.master)
  );

  axil_sram_slave #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH),
    .MEM_DEPTH  (MEM_DEPTH)
  ) u_sram (
    .i_aclk     (i_aclk),
    .i_arst_n   (i_arst_n),
    .s_axil     (axil.slave)
  );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the AXI-lite SRAM testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_axil_sram \
  -f axil_sram.f
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/Vtb_axil_sram > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
  echo "Test passed"
  exit 0
else
  echo "Test failed"
  exit 1
fi

//--- test/axil_sram_properties.sv
// Handshake assertions for the AXI-lite interface and request port, with their bind
module axil_sram_props #(
  parameter int  DATA_WIDTH = 64,
  parameter int  ADDR_WIDTH = 32,
  localparam int STRB_WIDTH = DATA_WIDTH / 8
) (
  input logic                  i_aclk,
  input logic                  i_arst_n,
  input logic                  i_rw_valid,
  input logic                  i_rw_ren,
  input logic                  i_rw_wen,
  input logic                  o_rw_ready,
  input logic                  i_awvalid,
  input logic                  i_awready,
  input logic [ADDR_WIDTH-1:0] i_awaddr,
  input logic                  i_wvalid,
  input logic                  i_wready,
  input logic [DATA_WIDTH-1:0] i_wdata,
  input logic [STRB_WIDTH-1:0] i_wstrb,
  input logic                  i_bvalid,
  input logic                  i_bready,
  input logic [1:0]            i_bresp,
  input logic                  i_arvalid,
  input logic                  i_arready,
  input logic [ADDR_WIDTH-1:0] i_araddr,
  input logic                  i_rvalid,
  input logic                  i_rready,
  input logic [DATA_WIDTH-1:0] i_rdata,
  input logic [1:0]            i_rresp
);
  timeunit 1ns;
  timeprecision 100ps;

  // ------------------------------------------------------------------------
  // Valid held with stable payload until ready
  // ------------------------------------------------------------------------
  a_aw_hold: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    i_awvalid && !i_awready |=> i_awvalid && $stable(i_awaddr))
    else $error("AW valid dropped or address changed before ready");

  a_w_hold: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    i_wvalid && !i_wready |=> i_wvalid && $stable(i_wdata) && $stable(i_wstrb))
    else $error("W valid dropped or payload changed before ready");

  a_b_hold: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    i_bvalid && !i_bready |=> i_bvalid && $stable(i_bresp))
    else $error("B valid dropped or response changed before ready");

  a_ar_hold: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
    else $error("AR valid dropped or address changed before ready");

  a_r_hold: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata) && $stable(i_rresp))
    else $error("R valid dropped or payload changed before ready");

  // Request port and completion
  a_one_op: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    i_rw_valid |-> !(i_rw_ren && i_rw_wen))
    else $error("Read and write requested together");

  a_ready_pulse: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    o_rw_ready |=> !o_rw_ready)
    else $error("Completion pulse longer than one cycle");

  a_aw_ar_excl: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    !(i_awvalid && i_arvalid))
    else $error("AW and AR valid high together");

endmodule

bind axil_sram_top axil_sram_props #(
  .DATA_WIDTH (DATA_WIDTH),
  .ADDR_WIDTH (ADDR_WIDTH)
) u_props (
  .i_aclk     (i_aclk),
  .i_arst_n   (i_arst_n),
  .i_rw_valid (i_rw_valid),
  .i_rw_ren   (i_rw_ren),
  .i_rw_wen   (i_rw_wen),
  .o_rw_ready (o_rw_ready),
  .i_awvalid  (axil.awvalid),
  .i_awready  (axil.awready),
  .i_awaddr   (axil.awaddr),
  .i_wvalid   (axil.wvalid),
  .i_wready   (axil.wready),
  .i_wdata    (axil.wdata),
  .i_wstrb    (axil.wstrb),
  .i_bvalid   (axil.bvalid),
  .i_bready   (axil.bready),
  .i_bresp    (axil.bresp),
  .i_arvalid  (axil.arvalid),
  .i_arready  (axil.arready),
  .i_araddr   (axil.araddr),
  .i_rvalid   (axil.rvalid),
  .i_rready   (axil.rready),
  .i_rdata    (axil.rdata),
  .i_rresp    (axil.rresp)
);

//--- test/tb_axil_sram.sv
// Testbench top: stimulus table, reference memory, random phase and checks
module tb_axil_sram;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int DATA_WIDTH = 64;
  localparam int ADDR_WIDTH = 32;
  localparam int MEM_DEPTH  = 256;
  localparam int TIMEOUT    = 50;   // Cycles per wait
  localparam int N_RANDOM   = 80;

  typedef logic [DATA_WIDTH-1:0]   data_t;
  typedef logic [ADDR_WIDTH-1:0]   addr_t;
  typedef logic [DATA_WIDTH/8-1:0] strb_t;

  logic  i_aclk;
  logic  i_arst_n;
  logic  i_rw_valid;
  logic  i_rw_ren;
  logic  i_rw_wen;
  addr_t i_rw_addr;
  data_t i_rw_wdata;
  strb_t i_rw_strb;
  logic  o_rw_ready;
  data_t o_rw_rdata;
  logic [1:0] o_rw_resp;

  // Stimulus table, one entry per index
  logic                 step_wr[$];
  addr_t                step_addr[$];
  data_t                step_data[$];
  strb_t                step_strb[$];
  data_t                step_exp[$];
  axil_pkg::axil_resp_t step_resp[$];

  data_t ref_mem [MEM_DEPTH];
  logic  written [MEM_DEPTH];

  tb_clkgen #(.PERIOD(4ns)) u_clk (.o_clk(i_aclk));

  axil_sram_top dut (
    .i_aclk     (i_aclk),
    .i_arst_n   (i_arst_n),
    .i_rw_valid (i_rw_valid),
    .i_rw_ren   (i_rw_ren),
    .i_rw_wen   (i_rw_wen),
    .i_rw_addr  (i_rw_addr),
    .i_rw_wdata (i_rw_wdata),
    .i_rw_strb  (i_rw_strb),
    .o_rw_ready (o_rw_ready),
    .o_rw_rdata (o_rw_rdata),
    .o_rw_resp  (o_rw_resp)
  );

  // ------------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Strobed bytes take the new value
  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input strb_t s);
    data_t r;
    r = old_w;
    for (int b = 0; b < DATA_WIDTH / 8; b++) begin
      if (s[b]) r[8*b +: 8] = new_w[8*b +: 8];
    end
    return r;
  endfunction

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_resp(input string name, input axil_pkg::axil_resp_t exp,
                            input axil_pkg::axil_resp_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act));
    end
  endtask

  task automatic add_step(input logic wr, input addr_t a, input data_t d, input strb_t s,
                          input data_t exp, input axil_pkg::axil_resp_t resp);
    step_wr.push_back(wr);
    step_addr.push_back(a);
    step_data.push_back(d);
    step_strb.push_back(s);
    step_exp.push_back(exp);
    step_resp.push_back(resp);
  endtask

  // Holds the request until the completion pulse, then drops it
  task automatic do_request(input logic wr, input addr_t a, input data_t d, input strb_t s,
                            input string tag, output data_t rdata,
                            output axil_pkg::axil_resp_t resp);
    int cycles;
    @(posedge i_aclk);
    #1;
    i_rw_valid = 1'b1;
    i_rw_wen   = wr;
    i_rw_ren   = !wr;
    i_rw_addr  = a;
    i_rw_wdata = d;
    i_rw_strb  = s;
    cycles = 0;
    @(negedge i_aclk);
    while (!o_rw_ready) begin
      cycles++;
      if (cycles > TIMEOUT) stop_on_error($sformatf("Request %s never completed", tag));
      @(negedge i_aclk);
    end
    rdata = o_rw_rdata;
    resp  = o_rw_resp;
    @(posedge i_aclk);
    #1;
    i_rw_valid = 1'b0;
    i_rw_wen   = 1'b0;
    i_rw_ren   = 1'b0;
    @(negedge i_aclk);
    if (o_rw_ready) stop_on_error($sformatf("Request %s gave a second ready pulse", tag));
  endtask

  // ------------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------------
  initial begin
    data_t                rdata;
    axil_pkg::axil_resp_t resp;
    logic [31:0]          rnd;
    int                   idx;
    logic                 wr;
    data_t                wdata;
    strb_t                strb;
    addr_t                addr;

    i_arst_n   = 1'b0;
    i_rw_valid = 1'b0;
    i_rw_ren   = 1'b0;
    i_rw_wen   = 1'b0;
    i_rw_addr  = '0;
    i_rw_wdata = '0;
    i_rw_strb  = '0;
    for (int i = 0; i < MEM_DEPTH; i++) begin
      ref_mem[i] = '0;
      written[i] = 1'b0;
    end

    repeat (2) @(posedge i_aclk);
    #1;
    i_arst_n = 1'b1;

    // Idle after reset
    repeat (8) begin
      @(negedge i_aclk);
      if (o_rw_ready) stop_on_error("o_rw_ready pulsed with no request");
    end

    add_step(1'b1, 32'h10, 64'h0123_4567_89ab_cdef, 8'hff, '0, axil_pkg::RESP_OKAY);
    add_step(1'b0, 32'h10, '0, '0, 64'h0123_4567_89ab_cdef, axil_pkg::RESP_OKAY);
    add_step(1'b1, 32'h10, 64'hffee_ddcc_bbaa_9988, 8'h0f, '0, axil_pkg::RESP_OKAY);
    add_step(1'b0, 32'h10, '0, '0, 64'h0123_4567_bbaa_9988, axil_pkg::RESP_OKAY);
    add_step(1'b1, 32'h18, 64'h1111_2222_3333_4444, 8'hff, '0, axil_pkg::RESP_OKAY);
    add_step(1'b1, 32'h18, 64'haabb_ccdd_eeff_0011, 8'ha5, '0, axil_pkg::RESP_OKAY);
    add_step(1'b0, 32'h18, '0, '0, 64'haa11_cc22_33ff_4411, axil_pkg::RESP_OKAY);
    // Out of range words whose low index bits land on words 2 and 3
    add_step(1'b1, 32'h810, 64'hdead_beef_dead_beef, 8'hff, '0, axil_pkg::RESP_SLVERR);
    add_step(1'b0, 32'h810, '0, '0, '0, axil_pkg::RESP_SLVERR);
    add_step(1'b1, 32'hffff_f818, 64'hcafe_f00d_cafe_f00d, 8'hff, '0, axil_pkg::RESP_SLVERR);
    add_step(1'b0, 32'h10, '0, '0, 64'h0123_4567_bbaa_9988, axil_pkg::RESP_OKAY);
    add_step(1'b0, 32'h18, '0, '0, 64'haa11_cc22_33ff_4411, axil_pkg::RESP_OKAY);

    foreach (step_wr[i]) begin
      do_request(step_wr[i], step_addr[i], step_data[i], step_strb[i],
                 $sformatf("table step %0d", i), rdata, resp);
      check_resp($sformatf("o_rw_resp step %0d", i), step_resp[i], resp);
      if (!step_wr[i]) begin
        check_data($sformatf("o_rw_rdata step %0d", i), step_exp[i], rdata);
      end else if (step_resp[i] == axil_pkg::RESP_OKAY) begin
        idx = int'(step_addr[i] >> 3);
        ref_mem[idx] = merge_bytes(ref_mem[idx], step_data[i], step_strb[i]);
        written[idx] = 1'b1;
      end
    end

    // ------------------------------------------------------------------------
    // Random in-range traffic against the reference memory
    // ------------------------------------------------------------------------
    rnd = 32'h97e0_45ba;
    for (int n = 0; n < N_RANDOM; n++) begin
      rnd = xorshift32(rnd);
      idx = int'(rnd[4:0]);
      wr  = rnd[8] | !written[idx];  // Unwritten words are written first
      strb = rnd[23:16];
      addr = {21'd0, rnd[7:0], 3'b000} & 32'h0000_00f8;
      rnd = xorshift32(rnd);
      wdata[31:0] = rnd;
      rnd = xorshift32(rnd);
      wdata[63:32] = rnd;
      if (!written[idx]) strb = 8'hff;
      do_request(wr, addr, wdata, strb, $sformatf("random %0d", n), rdata, resp);
      check_resp($sformatf("o_rw_resp random %0d", n), axil_pkg::RESP_OKAY, resp);
      if (wr) begin
        ref_mem[idx] = merge_bytes(ref_mem[idx], wdata, strb);
        written[idx] = 1'b1;
      end else begin
        check_data($sformatf("o_rw_rdata random %0d", n), ref_mem[idx], rdata);
      end
    end

    $display("** PASS **");
    $finish;
  end

endmodule

//--- test/tb_clkgen.sv
// Testbench clock generator
module tb_clkgen #(
  parameter realtime PERIOD = 4ns
) (
  output logic o_clk
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

endmodule
